// ==== design/decodePkg.sv ====
`default_nettype none

package decodePkg;

  // Widths with a meaning of their own
  typedef logic [15:0] instrT;   // One instruction word
  typedef logic [15:0] wordT;    // One register data word
  typedef logic [6:0]  opIdT;    // Operation number
  typedef logic [3:0]  regIdxT;  // Register index
  typedef logic [8:0]  offsetT;  // Bit 8 flags an I/O port offset
  typedef logic [3:0]  condT;    // Branch condition

  // Registers with a fixed role in the instruction set
  localparam regIdxT regLink  = 4'd13;
  localparam regIdxT regStack = 4'd14;
  localparam regIdxT regPc    = 4'd15;

  localparam condT condAlways = 4'hf;  // Unconditional

  // Special operation numbers
  localparam opIdT opIdIllegal   = 7'h7f;
  localparam opIdT opIdResetWord = 7'h64;  // All-ones word

  // Fields pulled out of one instruction word
  typedef struct packed {
    opIdT   opId;
    regIdxT regD;
    regIdxT regA;
    regIdxT regB;
    offsetT offset;
    condT   cond;
  } decodedT;

  // Decoded fields together with both source operands
  typedef struct packed {
    decodedT dec;
    wordT    opA;   // Value of regA
    wordT    opB;   // Value of regB
  } bundleT;

  // Writeback request, qualified by a separate wrEn
  typedef struct packed {
    regIdxT wrIdx;
    wordT   wrData;
  } wbT;

endpackage

`default_nettype wire

// ==== design/instrQueue.sv ====
`default_nettype none

module instrQueue #(
  parameter int QueueDepth = 2
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             inValid,
  input  decodePkg::instrT inInstr,
  output logic             inReady,
  output logic             headValid,
  input  logic             headReady,
  output decodePkg::instrT headInstr
);

  localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntW = $clog2(QueueDepth + 1);

  decodePkg::instrT mem [QueueDepth];  // Word storage
  logic [PtrW-1:0]  wrPtr;
  logic [PtrW-1:0]  rdPtr;
  logic [CntW-1:0]  count;             // Words held
  logic             push;
  logic             pop;

  // Advance a pointer with wrap at the queue depth
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    nextPtr = (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign inReady   = (count != CntW'(QueueDepth));
  assign headValid = (count != '0);
  assign headInstr = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop  = headValid && headReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= inInstr;  // Payload only
  end

endmodule

`default_nettype wire

// ==== design/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
  input  decodePkg::instrT   instr,
  output decodePkg::decodedT decoded
);

  logic [3:0] opcode;
  logic [3:0] f2;     // Function field, bits 11..8
  logic [1:0] f1;     // Function field, bits 7..6

  assign opcode = instr[15:12];
  assign f2     = instr[11:8];
  assign f1     = instr[7:6];

  always_comb begin
    decoded      = '0;
    decoded.cond = decodePkg::condAlways;

    case (opcode)
      4'd0: begin  // Ids 1 and 2
        decoded.opId   = instr[11] ? 7'd2 : 7'd1;
        decoded.offset = {4'd0, instr[10:6]};
        decoded.regD   = {1'b0, instr[2:0]};
        decoded.regA   = {1'b0, instr[5:3]};
      end
      4'd1: begin  // Ids 3 to 7
        decoded.regD = {1'b0, instr[2:0]};
        decoded.regA = {1'b0, instr[5:3]};
        if (!instr[11]) begin
          decoded.opId   = 7'd3;
          decoded.offset = {4'd0, instr[10:6]};
        end else begin
          decoded.opId = 7'd4 + {5'd0, instr[10:9]};
          if (!instr[10]) begin
            decoded.regB = {1'b0, instr[8:6]};    // Ids 4 and 5
          end else begin
            decoded.offset = {6'd0, instr[8:6]};  // Ids 6 and 7
          end
        end
      end
      4'd2, 4'd3: begin  // Ids 8 to 11
        decoded.opId   = {5'd0, opcode[0], instr[11]} + 7'd8;
        decoded.offset = {1'b0, instr[7:0]};
        decoded.regD   = {1'b0, instr[10:8]};
        decoded.regA   = {1'b0, instr[10:8]};
      end
      4'd4: begin
        if (instr[11]) begin  // Id 39
          decoded.opId   = 7'd39;
          decoded.offset = {1'b0, instr[7:0]};
          decoded.regD   = {1'b0, instr[10:8]};
          decoded.regA   = decodePkg::regPc;
          decoded.regB   = {1'b0, instr[10:8]};
        end else begin
          decoded.regD = {1'b0, instr[2:0]};
          decoded.regA = {1'b0, instr[2:0]};
          decoded.regB = {1'b0, instr[5:3]};
          case (f2)
            4'd0, 4'd1, 4'd2, 4'd3: begin  // Ids 12 to 27
              decoded.opId = 7'd12 + {3'd0, f2[1:0], f1};
            end
            4'd4: begin  // Ids 28 to 30
              case (f1)
                2'd1: begin
                  decoded.opId    = 7'd28;
                  decoded.regB[3] = 1'b1;
                end
                2'd2: begin
                  decoded.opId    = 7'd29;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                end
                2'd3: begin
                  decoded.opId    = 7'd30;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                  decoded.regB[3] = 1'b1;
                end
                default: decoded.opId = 7'd12;
              endcase
            end
            4'd5: begin  // Ids 31 to 33
              case (f1)
                2'd1: begin
                  decoded.opId    = 7'd31;
                  decoded.regB[3] = 1'b1;
                end
                2'd2: begin
                  decoded.opId    = 7'd32;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                end
                2'd3: begin
                  decoded.opId    = 7'd33;
                  decoded.regD[3] = 1'b1;
                  decoded.regA[3] = 1'b1;
                  decoded.regB[3] = 1'b1;
                end
                default: decoded.opId = 7'd12;
              endcase
            end
            4'd6: begin  // Ids 34 to 37
              decoded.opId = 7'd34 + {5'd0, f1};
              if (f1 == 2'd1 || f1 == 2'd3) decoded.regB[3] = 1'b1;
              if (f1[1]) begin
                decoded.regD[3] = 1'b1;
                decoded.regA[3] = 1'b1;
              end
            end
            4'd7: begin  // Id 38, conditional form
              decoded.opId = 7'd38;
              decoded.cond = instr[7:4];
              decoded.regD = '0;
              decoded.regB = '0;
            end
            default: decoded.opId = 7'h7d;  // Unused opcode 4 function
          endcase
        end
      end
      4'd5: begin  // Ids 40 to 47
        decoded.opId = 7'd40 + {4'd0, instr[11:9]};
        decoded.regD = {1'b0, instr[2:0]};
        decoded.regA = {1'b0, instr[5:3]};
        decoded.regB = {1'b0, instr[8:6]};
      end
      4'd6, 4'd7, 4'd8: begin  // Ids 48 to 53
        decoded.opId   = 7'd48 + {2'd0, opcode - 4'd6, 1'b0} + {6'd0, instr[11]};
        decoded.regD   = {1'b0, instr[2:0]};
        decoded.regA   = {1'b0, instr[5:3]};
        decoded.offset = {4'd0, instr[10:6]};
      end
      4'd9: begin  // Ids 54 and 55, stack relative
        decoded.opId   = instr[11] ? 7'd55 : 7'd54;
        decoded.offset = {1'b0, instr[7:0]};
        decoded.regD   = {1'b0, instr[10:8]};
        decoded.regA   = decodePkg::regStack;
      end
      4'd10: begin  // Ids 56 and 57
        decoded.opId   = instr[11] ? 7'd57 : 7'd56;
        decoded.offset = {1'b0, instr[7:0]};
        decoded.regD   = {1'b0, instr[10:8]};
        decoded.regA   = instr[11] ? decodePkg::regStack : decodePkg::regPc;
      end
      4'd11: begin
        case (f2)
          4'd0: decoded.opId = 7'd58;
          4'd2: begin  // Ids 59 to 62
            decoded.opId = 7'd59 + {5'd0, f1};
            decoded.regD = {1'b0, instr[2:0]};
            decoded.regB = {1'b0, instr[5:3]};
          end
          4'd10: begin  // Ids 63 to 66
            decoded.opId = 7'd63 + {5'd0, f1};
            decoded.regD = {1'b0, instr[2:0]};
            decoded.regB = {1'b0, instr[5:3]};
          end
          4'd4, 4'd13: begin
            decoded.opId = f2[0] ? 7'd68 : 7'd67;
            decoded.regD = {1'b0, instr[2:0]};
          end
          4'd14: begin
            if (f1 != 2'd3) begin  // Port access, ids 69 to 71
              decoded.opId   = 7'd69 + {5'd0, f1};
              decoded.regD   = {1'b0, instr[2:0]};
              decoded.offset = {1'b1, 6'd0, f1};
            end else begin
              decoded.opId = 7'h7a;
            end
          end
          default: decoded.opId = 7'h7a;  // Unused opcode 11 function
        endcase
      end
      4'd12: begin  // Id 72, software interrupt
        decoded.opId   = 7'd72;
        decoded.offset = 9'd9;
        decoded.regB   = decodePkg::regLink;
      end
      4'd13: begin  // Id 73, branch
        decoded.opId   = 7'd73;
        decoded.cond   = instr[11:8];
        decoded.offset = {1'b0, instr[7:0]};
        decoded.regA   = decodePkg::regPc;
      end
      4'd14: decoded.opId = instr[11] ? 7'd75 : 7'd74;
      default: begin
        decoded.opId = (instr == 16'hffff) ? decodePkg::opIdResetWord
                                           : decodePkg::opIdIllegal;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`default_nettype none

module regFile (
  input  logic              clk,
  input  logic              rstN,
  input  logic              wrEn,
  input  decodePkg::wbT     wb,
  input  decodePkg::regIdxT rdIdxA,
  input  decodePkg::regIdxT rdIdxB,
  output decodePkg::wordT   rdDataA,
  output decodePkg::wordT   rdDataB
);

  localparam int NumRegs = 2 ** $bits(decodePkg::regIdxT);

  decodePkg::wordT regs [NumRegs];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;  // All registers start at zero
      end
    end else if (wrEn) begin
      regs[wb.wrIdx] <= wb.wrData;
    end
  end

  // Read ports see the old value during a write
  assign rdDataA = regs[rdIdxA];
  assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

// ==== design/operandStage.sv ====
`default_nettype none

module operandStage (
  input  logic               clk,
  input  logic               rstN,
  input  logic               headValid,
  output logic               headReady,
  input  decodePkg::decodedT decoded,
  output decodePkg::regIdxT  rdIdxA,
  output decodePkg::regIdxT  rdIdxB,
  input  decodePkg::wordT    rdDataA,
  input  decodePkg::wordT    rdDataB,
  input  logic               wrEn,
  input  decodePkg::wbT      wb,
  output logic               outValid,
  input  logic               outReady,
  output decodePkg::bundleT  outBundle
);

  logic            load;
  decodePkg::wordT opA;
  decodePkg::wordT opB;

  // Register is free when empty or being drained this cycle
  assign headReady = !outValid || outReady;
  assign load      = headValid && headReady;

  assign rdIdxA = decoded.regA;
  assign rdIdxB = decoded.regB;

  // Same-edge writeback bypass
  assign opA = (wrEn && wb.wrIdx == decoded.regA) ? wb.wrData : rdDataA;
  assign opB = (wrEn && wb.wrIdx == decoded.regB) ? wb.wrData : rdDataB;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (load) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;  // Drained with nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      outBundle.dec <= decoded;
      outBundle.opA <= opA;
      outBundle.opB <= opB;
    end
  end

endmodule

`default_nettype wire

// ==== design/decodeTop.sv ====
`default_nettype none

module decodeTop #(
  parameter int QueueDepth = 2
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inValid,
  output logic              inReady,
  input  decodePkg::instrT  inInstr,
  output logic              outValid,
  input  logic              outReady,
  output decodePkg::bundleT outBundle,
  input  logic              wrEn,
  input  decodePkg::wbT     wb
);

  logic               headValid;
  logic               headReady;
  decodePkg::instrT   headInstr;
  decodePkg::decodedT decoded;     // Fields of the queue head
  decodePkg::regIdxT  rdIdxA;
  decodePkg::regIdxT  rdIdxB;
  decodePkg::wordT    rdDataA;
  decodePkg::wordT    rdDataB;

  instrQueue #(
    .QueueDepth(QueueDepth)
  ) uQueue (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .inInstr   (inInstr),
    .inReady   (inReady),
    .headValid (headValid),
    .headReady (headReady),
    .headInstr (headInstr)
  );

  instrDecoder uDecoder (
    .instr   (headInstr),
    .decoded (decoded)
  );

  regFile uRegFile (
    .clk     (clk),
    .rstN    (rstN),
    .wrEn    (wrEn),
    .wb      (wb),
    .rdIdxA  (rdIdxA),
    .rdIdxB  (rdIdxB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  operandStage uOperand (
    .clk       (clk),
    .rstN      (rstN),
    .headValid (headValid),
    .headReady (headReady),
    .decoded   (decoded),
    .rdIdxA    (rdIdxA),
    .rdIdxB    (rdIdxB),
    .rdDataA   (rdDataA),
    .rdDataB   (rdDataB),
    .wrEn      (wrEn),
    .wb        (wb),
    .outValid  (outValid),
    .outReady  (outReady),
    .outBundle (outBundle)
  );

endmodule

`default_nettype wire

// ==== tests/decodeTop_sva.sv ====
`default_nettype none

module decodeTopSva (
  input logic              clk,
  input logic              rstN,
  input logic              inReady,
  input logic              outValid,
  input logic              outReady,
  input decodePkg::bundleT outBundle,
  input logic              headValid,
  input logic              headReady
);

  // Stalled bundle holds still
  aOutHold: assert property (@(posedge clk) disable iff (!rstN)
    (outValid && !outReady) |=> (outValid && $stable(outBundle)))
    else $error("Output bundle changed while stalled");

  aResetState: assert property (@(posedge clk) $rose(rstN) |-> (!outValid && inReady))
    else $error("Wrong stream state after reset release");

  // Queue head is withdrawn only by a pop
  aHeadHold: assert property (@(posedge clk) disable iff (!rstN)
    (headValid && !headReady) |=> headValid)
    else $error("Queue head dropped without a transfer");

endmodule

bind decodeTop decodeTopSva uSva (
  .clk       (clk),
  .rstN      (rstN),
  .inReady   (inReady),
  .outValid  (outValid),
  .outReady  (outReady),
  .outBundle (outBundle),
  .headValid (headValid),
  .headReady (headReady)
);

`default_nettype wire

// ==== tests/decodeRef.svh ====
// Register contents as the DUT should hold them
logic [15:0] shadow [16] = '{default: '0};

// Decode table model, one case per opcode
function automatic decodePkg::decodedT refDecode(input decodePkg::instrT w);
  decodePkg::decodedT d;
  logic [3:0] f2;
  logic [1:0] f1;
  logic [3:0] lo;   // Bits 2..0
  logic [3:0] mid;  // Bits 5..3
  logic [3:0] hi;   // Bits 10..8
  d = '0;
  d.cond = 4'd15;
  f2 = w[11:8];
  f1 = w[7:6];
  lo = {1'b0, w[2:0]};
  mid = {1'b0, w[5:3]};
  hi = {1'b0, w[10:8]};
  case (w[15:12])
    4'd0: begin
      d.opId = w[11] ? 7'd2 : 7'd1;
      d.offset = 9'(w[10:6]);
      d.regD = lo;
      d.regA = mid;
    end
    4'd1: begin
      d.regD = lo;
      d.regA = mid;
      if (!w[11]) begin
        d.opId = 7'd3;
        d.offset = 9'(w[10:6]);
      end else begin
        d.opId = 7'(4 + w[10:9]);
        if (d.opId < 7'd6) d.regB = {1'b0, w[8:6]};
        else d.offset = 9'(w[8:6]);
      end
    end
    4'd2, 4'd3: begin
      d.opId = 7'(8 + 2 * (w[15:12] - 2) + w[11]);
      d.offset = 9'(w[7:0]);
      d.regD = hi;
      d.regA = hi;
    end
    4'd4: begin
      if (w[11]) begin
        d.opId = 7'd39;
        d.offset = 9'(w[7:0]);
        d.regD = hi;
        d.regB = hi;
        d.regA = 4'd15;
      end else begin
        d.regD = lo;
        d.regA = lo;
        d.regB = mid;
        if (f2 < 4'd4) begin
          d.opId = 7'(12 + 4 * f2 + f1);
        end else if (f2 < 4'd7) begin
          if (f2 == 4'd6) d.opId = 7'(34 + f1);
          else if (f1 == 2'd0) d.opId = 7'd12;
          else d.opId = 7'(28 + 3 * (f2 - 4) + f1 - 1);
          if (f1[0]) d.regB[3] = 1'b1;  // High half of the register file
          if (f1[1]) begin
            d.regD[3] = 1'b1;
            d.regA[3] = 1'b1;
          end
        end else if (f2 == 4'd7) begin
          d.opId = 7'd38;
          d.cond = w[7:4];
          d.regD = '0;
          d.regB = '0;
        end else begin
          d.opId = 7'h7d;
        end
      end
    end
    4'd5: begin
      d.opId = 7'(40 + w[11:9]);
      d.regD = lo;
      d.regA = mid;
      d.regB = {1'b0, w[8:6]};
    end
    4'd6, 4'd7, 4'd8: begin
      d.opId = 7'(48 + 2 * (w[15:12] - 6) + w[11]);
      d.regD = lo;
      d.regA = mid;
      d.offset = 9'(w[10:6]);
    end
    4'd9, 4'd10: begin
      d.opId = 7'((w[15:12] == 4'd9 ? 54 : 56) + w[11]);
      d.offset = 9'(w[7:0]);
      d.regD = hi;
      d.regA = (w[15:12] == 4'd9 || w[11]) ? 4'd14 : 4'd15;  // Stack or PC base
    end
    4'd11: begin
      case (f2)
        4'd0: d.opId = 7'd58;
        4'd2, 4'd10: begin
          d.opId = 7'(((f2 == 4'd2) ? 59 : 63) + f1);
          d.regD = lo;
          d.regB = mid;
        end
        4'd4, 4'd13: begin
          d.opId = (f2 == 4'd4) ? 7'd67 : 7'd68;
          d.regD = lo;
        end
        4'd14: begin
          if (f1 != 2'd3) begin
            d.opId = 7'(69 + f1);
            d.regD = lo;
            d.offset = 9'(256 + f1);  // Port number
          end else begin
            d.opId = 7'h7a;
          end
        end
        default: d.opId = 7'h7a;
      endcase
    end
    4'd12: begin
      d.opId = 7'd72;
      d.offset = 9'd9;
      d.regB = 4'd13;
    end
    4'd13: begin
      d.opId = 7'd73;
      d.cond = w[11:8];
      d.offset = 9'(w[7:0]);
      d.regA = 4'd15;
    end
    4'd14: d.opId = w[11] ? 7'd75 : 7'd74;
    default: d.opId = (w == 16'hffff) ? 7'h64 : 7'h7f;
  endcase
  return d;
endfunction

// ==== tests/decodeTb.sv ====
`default_nettype none

module decodeTb;

  localparam int QueueDepth = 2;
  localparam int TotalWords = 16 + 100 + 600 + 300 + 20 + 6;
  localparam int CycleLimit = 4 * TotalWords + 200;

  logic               clk;
  logic               rstN;
  logic               inValid;
  logic               inReady;
  logic               outValid;
  logic               outReady;
  logic               wrEn;
  logic               randomReady;  // Lets the ready generator toggle outReady
  logic               readyDraw;    // Next random outReady value
  decodePkg::instrT   inInstr;
  decodePkg::bundleT  outBundle;
  decodePkg::bundleT  expBundle;
  decodePkg::wbT      wb;
  decodePkg::decodedT expQ [$];     // Words accepted and not yet seen at the output
  integer             seed;
  int                 cycles = 0;
  string              testName;

  `include "decodeRef.svh"

  decodeTop #(.QueueDepth(QueueDepth)) dut (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inInstr(inInstr),
    .outValid(outValid), .outReady(outReady), .outBundle(outBundle), .wrEn(wrEn), .wb(wb)
  );

  task automatic checkVal(input string name, input logic [67:0] expVal,
                          input logic [67:0] actVal);
    if (actVal !== expVal) begin
      $display("FAILED %s expected %h actual %h", name, expVal, actVal);
      $display("TEST FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  function automatic logic coin();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic decodePkg::instrT randWord();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // Holds the word until accepted, returns just after the accepting edge
  task automatic sendWord(input decodePkg::instrT word);
    inValid = 1'b1;
    inInstr = word;
    @(negedge clk);
    while (!inReady) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic writeReg(input decodePkg::regIdxT idx, input decodePkg::wordT data);
    wrEn = 1'b1;
    wb.wrIdx = idx;
    wb.wrData = data;
    @(posedge clk);
    #1;
    wrEn = 1'b0;
  endtask

  task automatic drain();
    randomReady = 1'b0;
    inValid = 1'b0;
    @(posedge clk);
    #1;
    outReady = 1'b1;
    while (expQ.size() != 0) @(posedge clk);
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Run did not finish within %0d cycles", CycleLimit);
      $display("TEST FAIL");
      $fatal(1, "Timeout");
    end
  end

  // Drawn on the edge, applied with the other inputs
  always @(posedge clk) begin
    if (randomReady) begin
      readyDraw = coin();
      #1;
      outReady = readyDraw;
    end
  end

  // Scoreboard, sampled mid-cycle where all inputs and outputs are settled
  always @(negedge clk) begin
    if (rstN) begin
      if (!inReady) checkVal("inReady drop", QueueDepth + 1, expQ.size());
      if (inValid && inReady) expQ.push_back(refDecode(inInstr));
      if (outValid && outReady) begin
        if (expQ.size() == 0) begin
          $display("Bundle appeared with no word outstanding in %s", testName);
          $display("TEST FAIL");
          $fatal(1, "Unexpected bundle");
        end
        expBundle.dec = expQ.pop_front();
        expBundle.opA = shadow[expBundle.dec.regA];
        expBundle.opB = shadow[expBundle.dec.regB];
        checkVal(testName, expBundle, outBundle);
      end
      if (wrEn) shadow[wb.wrIdx] = wb.wrData;  // Lands at the coming edge
    end
  end

  initial begin
    decodePkg::instrT   w;
    decodePkg::instrT   rnd;
    decodePkg::decodedT fields;
    seed = 14;
    rstN = 1'b0;
    inValid = 1'b0;
    inInstr = '0;
    outReady = 1'b1;
    wrEn = 1'b0;
    wb = '0;
    randomReady = 1'b0;
    testName = "reset";
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;
    checkVal("reset outValid", 68'd0, outValid);
    checkVal("reset inReady", 68'd1, inReady);
    for (int i = 0; i < 16; i++) begin
      if (i < 8) sendWord({4'h5, 3'd0, 3'(7 - i), 3'(i), 3'(i)});
      else sendWord({4'h4, 4'h6, 2'd3, 3'(15 - i), 3'(i)});  // Upper eight registers
    end
    drain();

    testName = "register read";
    for (int r = 0; r < 16; r++) writeReg(4'(r), randWord());
    for (int i = 0; i < 100; i++) sendWord(randWord());
    drain();

    testName = "decode";
    for (int i = 0; i < 600; i++) sendWord(randWord());
    drain();

    testName = "back-pressure";
    randomReady = 1'b1;
    for (int i = 0; i < 300; i++) begin
      if (coin()) begin
        inValid = 1'b0;
        @(posedge clk);
        #1;
      end
      sendWord(randWord());
    end
    drain();

    testName = "forwarding";
    for (int k = 0; k < 20; k++) begin
      rnd = randWord();
      w = {4'h5, 3'(k), rnd[8:0]};
      fields = refDecode(w);
      sendWord(w);
      inValid = 1'b0;
      writeReg(fields.regA, randWord());  // Same edge as the operand load
      checkVal("forwarding outValid", 68'd1, outValid);
      drain();
    end

    testName = "special encodings";
    sendWord(16'hffff);
    sendWord(16'hf000);
    sendWord(16'hb100);
    sendWord(16'hbec0);
    sendWord(16'hbe40);
    sendWord(16'h4000);
    drain();

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== decodeTop.f ====
+incdir+tests
design/decodePkg.sv
design/instrQueue.sv
design/instrDecoder.sv
design/regFile.sv
design/operandStage.sv
design/decodeTop.sv
tests/decodeTop_sva.sv
tests/decodeTb.sv
